/* logic/aluArray.sv */
`timescale 1ns/1ns

module aluArray import aluPkg::*; #(
    parameter int NumLanes = 4
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wbAddr   adr,
    input  dataWord datWr,
    output dataWord datRd,
    output logic    ack
);

    laneWrite  wr;
    readReq    rd;
    laneResult laneOut [NumLanes];

    wbDispatcher #(
        .NumLanes (NumLanes)
    ) dispatcher0 (
        .clk   (clk),
        .rstN  (rstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr),
        .ack   (ack),
        .wr    (wr),
        .rd    (rd)
    );

    // Each lane sees every write and keeps the ones for its index.
    for (genvar i = 0; i < NumLanes; i++) begin : genLane
        aluLane #(
            .LaneIndex (i)
        ) lane0 (
            .clk  (clk),
            .rstN (rstN),
            .wr   (wr),
            .out  (laneOut[i])
        );
    end

    resultCollector #(
        .NumLanes (NumLanes)
    ) collector0 (
        .clk   (clk),
        .rstN  (rstN),
        .lanes (laneOut),
        .rd    (rd),
        .datRd (datRd)
    );

endmodule

/* logic/aluLane.sv */
`timescale 1ns/1ns

module aluLane import aluPkg::*; #(
    parameter int LaneIndex = 0
) (
    input  logic      clk,
    input  logic      rstN,
    input  laneWrite  wr,
    output laneResult out
);

    dataWord    opA;
    dataWord    opB;
    aluOp       opCode;
    logic       start;  // One cycle after an operation write.
    logic       hit;
    dataWord    aluResult;
    branchFlags aluFlags;

    assign hit = wr.valid && (wr.lane == laneIndex'(LaneIndex));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opA    <= '0;
            opB    <= '0;
            opCode <= ADD;
            start  <= 1'b0;
        end else begin
            start <= hit && (wr.sel == regOp);
            if (hit) begin
                case (wr.sel)
                    regA:    opA <= wr.data;
                    regB:    opB <= wr.data;
                    regOp:   opCode <= aluOp'(wr.data[3:0]);
                    default: ;  // Select 3 holds no register.
                endcase
            end
        end
    end

    rvAlu alu0 (
        .a      (opA),
        .b      (opB),
        .op     (opCode),
        .result (aluResult),
        .flags  (aluFlags)
    );

    // Operand writes alone leave the stored result alone.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out <= '0;
        end else if (start) begin
            out.result <= aluResult;
            out.flags  <= aluFlags;
        end
    end

    // Equal and signed less-than exclude each other.
    flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
        start |=> !(out.flags.equal && out.flags.lessThan));

endmodule

/* logic/aluPkg.sv */
package aluPkg;

    typedef logic [63:0] dataWord;  // Operand or result word.
    typedef logic [31:0] halfWord;  // Low half used by the W forms.
    typedef logic [7:0]  wbAddr;    // Wishbone word address.
    typedef logic [7:0]  laneIndex;
    typedef logic [1:0]  regSel;

    // RV64I integer operations in lane encoding.
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        AND  = 4'd1,
        OR   = 4'd2,
        SUB  = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9,
        ADDW = 4'd10,
        SUBW = 4'd11,
        SLLW = 4'd12,
        SRLW = 4'd13,
        SRAW = 4'd14,
        RSVD = 4'd15
    } aluOp;

    // Branch compare of A against B, equal in bit 2.
    typedef struct packed {
        logic equal;
        logic lessThan;   // Signed.
        logic lessThanU;  // Unsigned.
    } branchFlags;

    typedef struct packed {
        dataWord    result;
        branchFlags flags;
    } laneResult;

    typedef struct packed {
        logic     valid;
        laneIndex lane;
        regSel    sel;
        dataWord  data;
    } laneWrite;

    typedef struct packed {
        logic     valid;
        laneIndex lane;
        regSel    sel;
    } readReq;

    // Write side selects.
    localparam regSel regA      = 2'd0;
    localparam regSel regB      = 2'd1;
    localparam regSel regOp     = 2'd2;
    // Read side selects.
    localparam regSel regResult = 2'd0;
    localparam regSel regFlags  = 2'd1;

endpackage

/* logic/resultCollector.sv */
`timescale 1ns/1ns

module resultCollector import aluPkg::*; #(
    parameter int NumLanes = 4
) (
    input  logic      clk,
    input  logic      rstN,
    input  laneResult lanes [NumLanes],
    input  readReq    rd,
    output dataWord   datRd
);

    laneResult picked;
    logic      found;
    dataWord   selWord;

    // Lane mux. An index past the last lane finds nothing.
    always_comb begin
        picked = '0;
        found  = 1'b0;
        for (int i = 0; i < NumLanes; i++) begin
            if (int'(rd.lane) == i) begin
                picked = lanes[i];
                found  = 1'b1;
            end
        end
    end

    always_comb begin
        selWord = '0;
        if (found) begin
            case (rd.sel)
                regResult: selWord = picked.result;
                regFlags:  selWord = {61'd0, picked.flags};  // Zero extended.
                default:   selWord = '0;
            endcase
        end
    end

    // Loads on the edge that raises ack.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            datRd <= '0;
        end else if (rd.valid) begin
            datRd <= selWord;
        end
    end

endmodule

/* logic/rvAlu.sv */
`timescale 1ns/1ns

module rvAlu import aluPkg::*; (
    input  dataWord    a,
    input  dataWord    b,
    input  aluOp       op,
    output dataWord    result,
    output branchFlags flags
);

    logic        isSub;
    logic [64:0] addOut;  // Bit 64 is the carry out.
    dataWord     sum;
    logic        carry;
    logic        sltBit;
    logic        sltuBit;
    dataWord     sllRes;
    dataWord     srlRes;
    dataWord     sraRes;
    halfWord     sllW;
    halfWord     srlW;
    halfWord     sraW;

    function automatic dataWord sext32(input halfWord w);
        return {{32{w[31]}}, w};
    endfunction

    // One adder for add, subtract and the set-less-than forms.
    assign isSub  = (op == SUB) || (op == SUBW) || (op == SLT) || (op == SLTU);
    assign addOut = {1'b0, a} + {1'b0, (isSub ? ~b : b)} + 65'(isSub);
    assign sum    = addOut[63:0];
    assign carry  = addOut[64];

    // No carry out of a + ~b + 1 means a borrow.
    assign sltuBit = ~carry;
    // Signs differ, so the sign of A decides.
    assign sltBit  = (a[63] ^ b[63]) ? a[63] : sum[63];

    // Six bits of shift amount for the 64-bit forms.
    assign sllRes = a << b[5:0];
    assign srlRes = a >> b[5:0];
    assign sraRes = $signed(a) >>> b[5:0];

    // Five bits for the W forms.
    assign sllW = a[31:0] << b[4:0];
    assign srlW = a[31:0] >> b[4:0];
    assign sraW = $signed(a[31:0]) >>> b[4:0];

    always_comb begin
        case (op)
            ADD, SUB: result = sum;
            AND:      result = a & b;
            OR:       result = a | b;
            XOR:      result = a ^ b;
            SLT:      result = {63'd0, sltBit};
            SLTU:     result = {63'd0, sltuBit};
            SLL:      result = sllRes;
            SRL:      result = srlRes;
            SRA:      result = sraRes;
            ADDW, SUBW: begin
                result = sext32(sum[31:0]);  // Low half of the shared adder.
            end
            SLLW:     result = sext32(sllW);
            SRLW:     result = sext32(srlW);  // Extended like the others.
            SRAW:     result = sext32(sraW);
            default:  result = '0;             // RSVD.
        endcase
    end

    // Compare outputs follow A and B whatever op is.
    always_comb begin
        flags.equal     = ~|(a ^ b);
        flags.lessThan  = $signed(a) < $signed(b);
        flags.lessThanU = a < b;
    end

endmodule

/* logic/wbDispatcher.sv */
`timescale 1ns/1ns

module wbDispatcher import aluPkg::*; #(
    parameter int NumLanes = 4
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wbAddr    adr,
    input  dataWord  datWr,
    output logic     ack,
    output laneWrite wr,
    output readReq   rd
);

    logic     accept;
    laneIndex lane;
    regSel    sel;
    logic     inRange;

    // A new access is one the slave has not yet acknowledged.
    assign accept = cyc && stb && !ack;

    // Upper address bits pick the lane, low two the register.
    assign lane    = laneIndex'(adr[7:2]);
    assign sel     = adr[1:0];
    assign inRange = int'(lane) < NumLanes;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;  // Single cycle pulse.
        end
    end

    always_comb begin
        // Out of range writes are still acknowledged but go nowhere.
        wr.valid = accept && we && inRange;
        wr.lane  = lane;
        wr.sel   = sel;
        wr.data  = datWr;
    end

    always_comb begin
        rd.valid = accept && !we;
        rd.lane  = lane;
        rd.sel   = sel;
    end

    // Every access takes two cycles.
    ackPulse: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> !ack);

    noDualValid: assert property (@(posedge clk) disable iff (!rstN)
        !(wr.valid && rd.valid));

endmodule

/* sim.f */
logic/aluPkg.sv
logic/rvAlu.sv
logic/aluLane.sv
logic/wbDispatcher.sv
logic/resultCollector.sv
logic/aluArray.sv
verification/aluChecker.sv
verification/aluArrayTb.sv

/* verification/aluArrayTb.sv */
`timescale 1ns/1ns

module aluArrayTb import aluPkg::*; ();

    localparam int NumLanes      = 4;
    localparam int OpRuns        = 40;
    localparam int FlagRuns      = 48;
    localparam int ResetAccesses = NumLanes * 2;
    localparam int OpAccesses    = 15 * OpRuns * 4;
    localparam int FlagAccesses  = FlagRuns * 4;
    localparam int LaneAccesses  = NumLanes * 6;
    localparam int EdgeAccesses  = 4 + 3 + NumLanes + 2;
    localparam int TotalAccesses = ResetAccesses + OpAccesses + FlagAccesses
                                 + LaneAccesses + EdgeAccesses;
    localparam int CycleLimit    = (TotalAccesses * 3 + 8) * 2;

    logic       clk;
    logic       rstN;
    logic       cyc;
    logic       stb;
    logic       we;
    wbAddr      adr;
    dataWord    datWr;
    dataWord    datRd;
    logic       ack;
    dataWord    rngState;
    dataWord    modelRes [NumLanes];  // Expected stored result per lane.
    branchFlags modelFlg [NumLanes];
    int         readTag = 0;
    int         cycleCount = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;

    aluArray #(.NumLanes(NumLanes)) dut0 (
        .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .datWr(datWr), .datRd(datRd), .ack(ack)
    );

    aluChecker checker0 (
        .clk(clk), .cyc(cyc), .stb(stb), .we(we), .ack(ack), .datRd(datRd)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles, a bus access never finished", cycleCount);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic dataWord nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 7;
        rngState ^= rngState << 17;
        return rngState;
    endfunction

    function automatic dataWord signExtend(input halfWord w);
        return {{32{w[31]}}, w};
    endfunction

    // Reference results straight from the RV64I rules.
    function automatic dataWord aluModel(input dataWord a, input dataWord b, input aluOp op);
        halfWord lowA;
        halfWord tmpW;
        dataWord res;
        lowA = a[31:0];
        case (op)
            ADD:  res = a + b;
            AND:  res = a & b;
            OR:   res = a | b;
            SUB:  res = a - b;
            XOR:  res = a ^ b;
            SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU: res = (a < b) ? 64'd1 : 64'd0;
            SLL:  res = a << b[5:0];
            SRL:  res = a >> b[5:0];
            SRA:  res = $signed(a) >>> b[5:0];
            ADDW: res = signExtend(halfWord'(a + b));
            SUBW: res = signExtend(halfWord'(a - b));
            SLLW: begin
                tmpW = lowA << b[4:0];
                res  = signExtend(tmpW);
            end
            SRLW: begin
                tmpW = lowA >> b[4:0];
                res  = signExtend(tmpW);
            end
            SRAW: begin
                tmpW = $signed(lowA) >>> b[4:0];
                res  = signExtend(tmpW);
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic branchFlags flagModel(input dataWord a, input dataWord b);
        return {a == b, $signed(a) < $signed(b), a < b};
    endfunction

    function automatic wbAddr addrOf(input int lane, input regSel sel);
        return wbAddr'(lane * 4 + int'(sel));
    endfunction

    task automatic busAccess(input logic isWrite, input wbAddr addr, input dataWord data);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= isWrite;
        adr   <= addr;
        datWr <= data;
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    // Writing the operation starts the lane and updates the model.
    task automatic runOp(input int lane, input dataWord a, input dataWord b, input aluOp op);
        busAccess(1'b1, addrOf(lane, regA), a);
        busAccess(1'b1, addrOf(lane, regB), b);
        busAccess(1'b1, addrOf(lane, regOp), 64'(op));
        if (lane < NumLanes) begin
            modelRes[lane] = aluModel(a, b, op);
            modelFlg[lane] = flagModel(a, b);
        end
    endtask

    task automatic readLane(input int lane, input regSel sel);
        dataWord expected;
        expected = '0;  // Out of range lanes read as zero.
        if (lane < NumLanes) begin
            expected = (sel == regFlags) ? {61'd0, modelFlg[lane]} : modelRes[lane];
        end
        readTag++;
        checker0.pushExpected(expected, readTag);
        busAccess(1'b0, addrOf(lane, sel), '0);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (checker0.errorCount == errorsBefore) begin
            $display("Test %s: pass", name);
            testsPassed++;
        end else begin
            $display("Test %s: fail, %0d errors", name, checker0.errorCount - errorsBefore);
            testsFailed++;
        end
    endtask

    task automatic sweepOperations();
        int      errorsBefore;
        dataWord a;
        dataWord b;
        int      lane;
        errorsBefore = checker0.errorCount;
        for (int opIdx = 0; opIdx < 15; opIdx++) begin
            for (int i = 0; i < OpRuns; i++) begin
                a    = nextRandom();
                b    = nextRandom();
                lane = int'(nextRandom() % NumLanes);
                if (i % 4 == 1) b[5:0] = 6'(31 + int'(nextRandom() % 33));
                if (i % 4 >= 2) a[31] = 1'b1;
                if (i % 4 == 3) b[31] = 1'b1;
                runOp(lane, a, b, aluOp'(opIdx));
                readLane(lane, regResult);
            end
        end
        finishTest("every operation", errorsBefore);
    endtask

    task automatic exerciseFlags();
        int      errorsBefore;
        dataWord a;
        dataWord b;
        int      lane;
        errorsBefore = checker0.errorCount;
        for (int i = 0; i < FlagRuns; i++) begin
            a    = nextRandom();
            b    = nextRandom();
            lane = int'(nextRandom() % NumLanes);
            if (i % 3 == 1) b = a;                 // Forced equal.
            if (i % 3 == 2) b[63] = ~a[63];        // Opposite signs.
            runOp(lane, a, b, aluOp'(nextRandom() % 16));
            readLane(lane, regFlags);
        end
        finishTest("branch flags", errorsBefore);
    endtask

    task automatic isolateLanes();
        int errorsBefore;
        int order [NumLanes];
        int pick;
        int tmp;
        errorsBefore = checker0.errorCount;
        for (int lane = 0; lane < NumLanes; lane++) begin
            order[lane] = lane;
            runOp(lane, nextRandom(), nextRandom(), aluOp'(lane * 4 + 1));
        end
        for (int pass = 0; pass < 2; pass++) begin
            // Shuffle the read order.
            for (int i = NumLanes - 1; i > 0; i--) begin
                pick        = int'(nextRandom() % (i + 1));
                tmp         = order[i];
                order[i]    = order[pick];
                order[pick] = tmp;
            end
            for (int i = 0; i < NumLanes; i++) readLane(order[i], regResult);
            // Operand A alone must not disturb the stored result.
            if (pass == 0) begin
                for (int lane = 0; lane < NumLanes; lane++) begin
                    busAccess(1'b1, addrOf(lane, regA), nextRandom());
                end
            end
        end
        finishTest("lane independence", errorsBefore);
    endtask

    task automatic edgeAddressing();
        int errorsBefore;
        int ackSnapshot;
        errorsBefore = checker0.errorCount;
        ackSnapshot  = checker0.ackCount;
        runOp(0, nextRandom(), nextRandom(), RSVD);
        readLane(0, regResult);
        runOp(5, nextRandom(), nextRandom(), ADD);  // Dropped by the slave.
        for (int lane = 0; lane < NumLanes; lane++) readLane(lane, regResult);
        readLane(5, regResult);
        readLane(5, regFlags);
        checker0.checkAckCount(ackSnapshot, EdgeAccesses);
        finishTest("addressing and RSVD", errorsBefore);
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datWr    = '0;
        rngState = 64'd47;
        for (int lane = 0; lane < NumLanes; lane++) begin
            modelRes[lane] = '0;
            modelFlg[lane] = '0;
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        for (int lane = 0; lane < NumLanes; lane++) begin
            readLane(lane, regResult);
            readLane(lane, regFlags);
        end
        finishTest("reset state", 0);
        sweepOperations();
        exerciseFlags();
        isolateLanes();
        edgeAddressing();

        @(posedge clk);
        checker0.reportLeftovers();
        $display("Tests passed %0d, failed %0d, reads checked %0d, errors %0d",
                 testsPassed, testsFailed, checker0.checkCount, checker0.errorCount);
        if (checker0.errorCount == 0 && testsFailed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verification/aluChecker.sv */
`timescale 1ns/1ns

module aluChecker import aluPkg::*; (
    input logic    clk,
    input logic    cyc,
    input logic    stb,
    input logic    we,
    input logic    ack,
    input dataWord datRd
);

    dataWord expQueue [$];  // Expected read data in arrival order.
    int      tagQueue [$];
    dataWord expValue;
    int      expTag;
    int      errorCount = 0;
    int      checkCount = 0;
    int      ackCount   = 0;

    task automatic pushExpected(input dataWord value, input int tag);
        expQueue.push_back(value);
        tagQueue.push_back(tag);
    endtask

    // Compares the acks seen since a snapshot with the number of accesses made.
    task automatic checkAckCount(input int ackSnapshot, input int accesses);
        if (ackCount - ackSnapshot != accesses) begin
            $display("%0d acks were seen for %0d bus accesses at %0t",
                     ackCount - ackSnapshot, accesses, $time);
            errorCount++;
        end
    endtask

    task automatic reportLeftovers();
        if (expQueue.size() != 0) begin
            $display("%0d expected read values were never matched by a read",
                     expQueue.size());
            errorCount++;
        end
    endtask

    // A held or stray ack adds to the count.
    always @(negedge clk) begin
        if (ack) begin
            ackCount++;
        end
        if (cyc && stb && ack && !we) begin
            if (expQueue.size() == 0) begin
                $display("A read completed at %0t with no expected value queued",
                         $time);
                errorCount++;
            end else begin
                expValue = expQueue.pop_front();
                expTag   = tagQueue.pop_front();
                checkCount++;
                if (datRd !== expValue) begin
                    $display("[FAIL] %0t ns datRd expected %h actual %h (read %0d)",
                             $time, expValue, datRd, expTag);
                    errorCount++;
                end
            end
        end
    end

endmodule
